// File: design/datapath_ctrl_gen.sv
// Datapath control generation
// Turns the instruction name into ALU, register file, write-back,
// immediate, hi/lo and load/store controls. Invalid gives all zeros.

`timescale 1ns/1ps

module datapath_ctrl_gen (
	input  decode_pkg::inst_e     inst_name,
	output decode_pkg::alu_op_e   alu_op,
	output decode_pkg::ls_class_e ls_class,
	output logic [1:0]            add_sub,
	output logic [1:0]            hilo_mode,
	output logic                  load,
	output logic                  r1_r,
	output logic                  r2_r,
	output logic                  r1_sel,
	output logic                  r2_sel,
	output logic                  regs_we,
	output logic [1:0]            rw_sel,
	output logic [2:0]            din_sel,
	output logic                  cp0_we,
	output logic [1:0]            ext_sel,
	output logic [1:0]            alua_sel,
	output logic [1:0]            alub_sel
);

	import decode_pkg::*;

	// signed overflow check, bit 1 for sub
	assign add_sub = {inst_name == INST_SUB, inst_name inside {INST_ADD, INST_ADDI}};
	assign load    = inst_name inside {INST_LB, INST_LBU, INST_LH, INST_LHU, INST_LW};
	assign cp0_we  = inst_name == INST_MTC0;

	always_comb begin
		case (inst_name)
			INST_ADD, INST_ADDI, INST_ADDU, INST_ADDIU,
			INST_LB, INST_LBU, INST_LH, INST_LHU, INST_LW,
			INST_SB, INST_SH, INST_SW:         alu_op = ALU_ADD;	// address add too
			INST_SUB, INST_SUBU:               alu_op = ALU_SUB;
			INST_SLT, INST_SLTI:               alu_op = ALU_SLT;
			INST_SLTU, INST_SLTIU,
			INST_MULT, INST_MUL:               alu_op = ALU_MULT;
			INST_AND, INST_ANDI:               alu_op = ALU_AND;
			INST_OR, INST_ORI:                 alu_op = ALU_OR;
			INST_XOR, INST_XORI:               alu_op = ALU_XOR;
			INST_NOR:                          alu_op = ALU_NOR;
			INST_SRA, INST_SRAV:               alu_op = ALU_SRA;
			INST_SRL, INST_SRLV:               alu_op = ALU_SRL;
			INST_MULTU:                        alu_op = ALU_MULTU;
			INST_DIV:                          alu_op = ALU_DIV;
			INST_DIVU:                         alu_op = ALU_DIVU;
			default:                           alu_op = ALU_SLL;
		endcase
	end

	always_comb begin
		case (inst_name)
			INST_LBU: ls_class = LS_LBU;
			INST_LH:  ls_class = LS_LH;
			INST_LHU: ls_class = LS_LHU;
			INST_LW:  ls_class = LS_LW;
			INST_SB:  ls_class = LS_SB;
			INST_SH:  ls_class = LS_SH;
			INST_SW:  ls_class = LS_SW;
			default:  ls_class = LS_LB;
		endcase
	end

	// rw_sel 10 rd, 01 rt, 00 link register
	// din_sel 110 alu, 100 hi, 101 lo, 011 cp0, 010 memory, 001 return address
	always_comb begin
		hilo_mode = 2'b00;
		r1_r      = 1'b0;
		r2_r      = 1'b0;
		r1_sel    = 1'b0;
		r2_sel    = 1'b0;
		regs_we   = 1'b0;
		rw_sel    = 2'b00;
		din_sel   = 3'b000;
		ext_sel   = 2'b00;
		alua_sel  = 2'b00;
		alub_sel  = 2'b00;
		case (inst_name)
			INST_ADD, INST_ADDU, INST_SUB, INST_SUBU, INST_SLT, INST_SLTU,
			INST_AND, INST_OR, INST_XOR, INST_NOR: begin
				{r1_r, r2_r, r2_sel, regs_we} = 4'b1111;
				rw_sel  = 2'b10;
				din_sel = 3'b110;
			end
			INST_SLLV, INST_SRAV, INST_SRLV: begin
				{r1_r, r2_r, r1_sel, regs_we} = 4'b1111;	// shift amount from rs
				rw_sel  = 2'b10;
				din_sel = 3'b110;
			end
			INST_SLL, INST_SRA, INST_SRL: begin
				{r2_r, r2_sel, regs_we} = 3'b111;
				rw_sel   = 2'b10;
				din_sel  = 3'b110;
				ext_sel  = 2'b10;	// shamt as operand
				alua_sel = 2'b01;
				alub_sel = 2'b01;
			end
			INST_ADDI, INST_ADDIU, INST_SLTI, INST_SLTIU,
			INST_ANDI, INST_ORI, INST_XORI: begin
				{r1_r, regs_we} = 2'b11;
				rw_sel   = 2'b01;
				din_sel  = 3'b110;
				ext_sel  = {1'b0, inst_name inside {INST_ANDI, INST_ORI, INST_XORI}};
				alub_sel = 2'b01;
			end
			INST_LUI: begin
				regs_we  = 1'b1;
				rw_sel   = 2'b01;
				din_sel  = 3'b110;
				ext_sel  = 2'b01;
				alua_sel = 2'b10;
				alub_sel = 2'b11;
			end
			INST_MULT, INST_MULTU, INST_DIV, INST_DIVU: begin
				{r1_r, r2_r, r2_sel} = 3'b111;
				hilo_mode = 2'b11;	// writes both hi and lo
			end
			INST_MUL: begin
				{r2_sel, regs_we} = 2'b11;
				rw_sel  = 2'b10;
				din_sel = 3'b110;
			end
			INST_BEQ, INST_BEQL, INST_BNE, INST_BGTZ, INST_BLEZ: begin
				{r1_r, r2_r, r2_sel} = 3'b111;
			end
			INST_BGEZ, INST_BLTZ: begin
				r1_r     = 1'b1;
				alub_sel = 2'b10;	// compare against zero
			end
			INST_BLTZAL, INST_BGEZAL: begin
				{r1_r, regs_we} = 2'b11;
				din_sel  = 3'b001;
				alub_sel = 2'b10;
			end
			INST_JAL: begin
				regs_we = 1'b1;
				din_sel = 3'b001;
			end
			INST_JR: r1_r = 1'b1;
			INST_JALR: begin
				{r1_r, regs_we} = 2'b11;
				rw_sel  = 2'b10;
				din_sel = 3'b001;
			end
			INST_MFHI, INST_MFLO: begin
				regs_we = 1'b1;
				rw_sel  = 2'b10;
				din_sel = {2'b10, inst_name == INST_MFLO};
			end
			INST_MTHI, INST_MTLO: begin
				r1_r      = 1'b1;
				hilo_mode = {inst_name == INST_MTHI, inst_name == INST_MTLO};
			end
			INST_MFC0: begin
				regs_we = 1'b1;
				rw_sel  = 2'b01;
				din_sel = 3'b011;
			end
			INST_MTC0: {r2_r, r2_sel} = 2'b11;
			INST_ERET: r2_r = 1'b1;
			INST_LB, INST_LBU, INST_LH, INST_LHU, INST_LW: begin
				{r1_r, regs_we} = 2'b11;
				rw_sel   = 2'b01;
				din_sel  = 3'b010;
				alub_sel = 2'b01;
			end
			INST_SB, INST_SH, INST_SW: begin
				{r1_r, r2_r, r2_sel} = 3'b111;
				alub_sel = 2'b01;
			end
			default: ;
		endcase
	end

endmodule

// File: design/decode_consts.svh
// Decode constants
// Instruction field widths and positions, opcode, func, regimm rt and
// cop0 rs codes, and the widths of the decode outputs.

`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define INST_W      32
`define OP_W        6
`define FUNC_W      6
`define REG_W       5

`define OP_LSB      26
`define RS_LSB      21
`define RT_LSB      16
`define SH_LSB      6

`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000
`define OP_BEQL     6'b010100
`define OP_SPECIAL2 6'b011100
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_SYSCALL  6'b001100
`define FN_BREAK    6'b001101
`define FN_MFHI     6'b010000
`define FN_MTHI     6'b010001
`define FN_MFLO     6'b010010
`define FN_MTLO     6'b010011
`define FN_MULT     6'b011000
`define FN_MULTU    6'b011001
`define FN_DIV      6'b011010
`define FN_DIVU     6'b011011
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011
`define FN_MUL      6'b000010
`define FN_ERET     6'b011000

`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

`define RS_MF       5'b00000
`define RS_MT       5'b00100

`define ALU_OP_W    4
`define BRANCH_W    11
`define CTRL_BUS_W  34

`endif

// File: design/decode_pkg.sv
// Decode types
// Instruction names, ALU operation codes and load/store classes shared
// by the decode stage.

`include "decode_consts.svh"

package decode_pkg;

	typedef enum logic [5:0] {
		INST_INVALID,
		INST_ADD, INST_ADDI, INST_ADDU, INST_ADDIU, INST_SUB, INST_SUBU,
		INST_SLT, INST_SLTI, INST_SLTU, INST_SLTIU,
		INST_AND, INST_ANDI, INST_OR, INST_ORI, INST_XOR, INST_XORI, INST_NOR, INST_LUI,
		INST_SLL, INST_SLLV, INST_SRA, INST_SRAV, INST_SRL, INST_SRLV,
		INST_MULT, INST_MULTU, INST_DIV, INST_DIVU, INST_MUL,
		INST_BEQ, INST_BEQL, INST_BNE, INST_BGEZ, INST_BGTZ, INST_BLEZ,
		INST_BLTZ, INST_BLTZAL, INST_BGEZAL,
		INST_J, INST_JAL, INST_JR, INST_JALR,
		INST_MFHI, INST_MFLO, INST_MTHI, INST_MTLO,
		INST_BREAK, INST_SYSCALL, INST_ERET, INST_MFC0, INST_MTC0,
		INST_LB, INST_LBU, INST_LH, INST_LHU, INST_LW, INST_SB, INST_SH, INST_SW
	} inst_e;

	typedef enum logic [`ALU_OP_W-1:0] {
		ALU_SLL   = 4'd0,
		ALU_SRA   = 4'd1,
		ALU_SRL   = 4'd2,
		ALU_MULTU = 4'd3,
		ALU_DIVU  = 4'd4,
		ALU_ADD   = 4'd5,
		ALU_SUB   = 4'd6,
		ALU_AND   = 4'd7,
		ALU_OR    = 4'd8,
		ALU_XOR   = 4'd9,
		ALU_NOR   = 4'd10,
		ALU_SLT   = 4'd11,
		ALU_MULT  = 4'd13,	// also sltu, sltiu and mul
		ALU_DIV   = 4'd14
	} alu_op_e;

	typedef enum logic [2:0] {
		LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LW, LS_SB, LS_SH, LS_SW
	} ls_class_e;

endpackage

// File: design/flow_ctrl_gen.sv
// Flow control generation
// Branch/jump vector, delay-slot flag and the exception flags
// (eret, break, syscall, invalid) from the instruction name.

`timescale 1ns/1ps
`include "decode_consts.svh"

module flow_ctrl_gen (
	input  decode_pkg::inst_e    inst_name,
	output logic [`BRANCH_W-1:0] branch_jump_c,
	output logic                 in_delayslot_c,
	output logic                 eret_c,
	output logic                 break_c,
	output logic                 syscall_c,
	output logic                 invalid_c
);

	import decode_pkg::*;

	always_comb begin
		branch_jump_c = '0;
		case (inst_name)
			INST_BEQ:            branch_jump_c[0] = 1'b1;
			INST_BNE:            branch_jump_c[1] = 1'b1;
			INST_BGEZ:           branch_jump_c[2] = 1'b1;
			INST_BGTZ:           branch_jump_c[3] = 1'b1;
			INST_BLEZ:           branch_jump_c[4] = 1'b1;
			INST_BLTZ:           branch_jump_c[5] = 1'b1;
			INST_BLTZAL:         branch_jump_c[6] = 1'b1;
			INST_BGEZAL:         branch_jump_c[7] = 1'b1;
			INST_J, INST_JAL:    branch_jump_c[8] = 1'b1;
			INST_JR, INST_JALR:  branch_jump_c[9] = 1'b1;
			INST_BEQL: begin
				branch_jump_c[10] = 1'b1;	// likely, shares the beq compare
				branch_jump_c[0]  = 1'b1;
			end
			default: ;
		endcase
	end

	assign in_delayslot_c = |branch_jump_c;	// next fetch sits in the slot
	assign eret_c         = inst_name == INST_ERET;
	assign break_c        = inst_name == INST_BREAK;
	assign syscall_c      = inst_name == INST_SYSCALL;
	assign invalid_c      = inst_name == INST_INVALID;

endmodule

// File: design/id_ctrl_reg.sv
// Decode output register
// Packs the datapath and flow controls into the control bus and
// registers them on the input strobe, with a one-cycle valid.

`timescale 1ns/1ps
`include "decode_consts.svh"

module id_ctrl_reg (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    inst_valid,
	input  logic                    not_nop,
	input  decode_pkg::alu_op_e     alu_op,
	input  decode_pkg::ls_class_e   ls_class,
	input  logic [1:0]              add_sub,
	input  logic [1:0]              hilo_mode,
	input  logic                    load,
	input  logic                    r1_r,
	input  logic                    r2_r,
	input  logic                    r1_sel,
	input  logic                    r2_sel,
	input  logic                    regs_we,
	input  logic [1:0]              rw_sel,
	input  logic [2:0]              din_sel,
	input  logic                    cp0_we,
	input  logic [1:0]              ext_sel,
	input  logic [1:0]              alua_sel,
	input  logic [1:0]              alub_sel,
	input  logic [`BRANCH_W-1:0]    branch_jump_c,
	input  logic                    in_delayslot_c,
	input  logic                    eret_c,
	input  logic                    break_c,
	input  logic                    syscall_c,
	input  logic                    invalid_c,
	output logic [`CTRL_BUS_W-1:0]  control_bus,
	output logic [`BRANCH_W-1:0]    branch_jump,
	output logic                    in_delayslot,
	output logic                    ctrl_valid
);

	logic [`CTRL_BUS_W-1:0] bus_next;

	assign bus_next = {
		add_sub, ls_class, invalid_c, eret_c, break_c, syscall_c,
		hilo_mode, not_nop, load, r2_r, r1_r,
		alub_sel, alua_sel, ext_sel, cp0_we,
		din_sel, rw_sel, regs_we, r2_sel, r1_sel,
		alu_op
	};

	always_ff @(posedge clk) begin
		if (rst) begin
			control_bus  <= '0;
			branch_jump  <= '0;
			in_delayslot <= 1'b0;
			ctrl_valid   <= 1'b0;
		end else begin
			ctrl_valid <= inst_valid;	// single-cycle pulse per strobe
			if (inst_valid) begin
				control_bus  <= bus_next;
				branch_jump  <= branch_jump_c;
				in_delayslot <= in_delayslot_c;
			end
		end
	end

endmodule

// File: design/inst_decode_top.sv
// Instruction decode stage
// Names each strobed instruction, derives datapath and flow controls,
// and presents the registered control bus one cycle later.

`timescale 1ns/1ps
`include "decode_consts.svh"

module inst_decode_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   inst_valid,
	input  logic [`INST_W-1:0]     inst,
	output logic [`CTRL_BUS_W-1:0] control_bus,
	output logic [`BRANCH_W-1:0]   branch_jump,
	output logic                   in_delayslot,
	output logic                   ctrl_valid
);

	import decode_pkg::*;

	inst_e                 inst_name;
	logic                  not_nop;
	alu_op_e               alu_op;
	ls_class_e             ls_class;
	logic [1:0]            add_sub;
	logic [1:0]            hilo_mode;
	logic                  load;
	logic                  r1_r;
	logic                  r2_r;
	logic                  r1_sel;
	logic                  r2_sel;
	logic                  regs_we;
	logic [1:0]            rw_sel;
	logic [2:0]            din_sel;
	logic                  cp0_we;
	logic [1:0]            ext_sel;
	logic [1:0]            alua_sel;
	logic [1:0]            alub_sel;
	logic [`BRANCH_W-1:0]  branch_jump_c;
	logic                  in_delayslot_c;
	logic                  eret_c;
	logic                  break_c;
	logic                  syscall_c;
	logic                  invalid_c;

	inst_identify u_identify (
		.inst      (inst),
		.inst_name (inst_name),
		.not_nop   (not_nop)
	);

	datapath_ctrl_gen u_datapath (
		.inst_name (inst_name),
		.alu_op    (alu_op),
		.ls_class  (ls_class),
		.add_sub   (add_sub),
		.hilo_mode (hilo_mode),
		.load      (load),
		.r1_r      (r1_r),
		.r2_r      (r2_r),
		.r1_sel    (r1_sel),
		.r2_sel    (r2_sel),
		.regs_we   (regs_we),
		.rw_sel    (rw_sel),
		.din_sel   (din_sel),
		.cp0_we    (cp0_we),
		.ext_sel   (ext_sel),
		.alua_sel  (alua_sel),
		.alub_sel  (alub_sel)
	);

	flow_ctrl_gen u_flow (
		.inst_name      (inst_name),
		.branch_jump_c  (branch_jump_c),
		.in_delayslot_c (in_delayslot_c),
		.eret_c         (eret_c),
		.break_c        (break_c),
		.syscall_c      (syscall_c),
		.invalid_c      (invalid_c)
	);

	id_ctrl_reg u_ctrl_reg (
		.clk            (clk),
		.rst            (rst),
		.inst_valid     (inst_valid),
		.not_nop        (not_nop),
		.alu_op         (alu_op),
		.ls_class       (ls_class),
		.add_sub        (add_sub),
		.hilo_mode      (hilo_mode),
		.load           (load),
		.r1_r           (r1_r),
		.r2_r           (r2_r),
		.r1_sel         (r1_sel),
		.r2_sel         (r2_sel),
		.regs_we        (regs_we),
		.rw_sel         (rw_sel),
		.din_sel        (din_sel),
		.cp0_we         (cp0_we),
		.ext_sel        (ext_sel),
		.alua_sel       (alua_sel),
		.alub_sel       (alub_sel),
		.branch_jump_c  (branch_jump_c),
		.in_delayslot_c (in_delayslot_c),
		.eret_c         (eret_c),
		.break_c        (break_c),
		.syscall_c      (syscall_c),
		.invalid_c      (invalid_c),
		.control_bus    (control_bus),
		.branch_jump    (branch_jump),
		.in_delayslot   (in_delayslot),
		.ctrl_valid     (ctrl_valid)
	);

endmodule

// File: design/inst_identify.sv
// Instruction identification
// Splits the instruction word into its fields and names the instruction.
// Anything not recognised comes out as INST_INVALID.

`timescale 1ns/1ps
`include "decode_consts.svh"

module inst_identify (
	input  logic [`INST_W-1:0] inst,
	output decode_pkg::inst_e  inst_name,
	output logic               not_nop
);

	import decode_pkg::*;

	logic [`OP_W-1:0]   op;
	logic [`REG_W-1:0]  rs;
	logic [`REG_W-1:0]  rt;
	logic [`FUNC_W-1:0] func;

	assign op   = inst[`OP_LSB +: `OP_W];
	assign rs   = inst[`RS_LSB +: `REG_W];
	assign rt   = inst[`RT_LSB +: `REG_W];
	assign func = inst[`FUNC_W-1:0];

	// all-zero word is the only nop
	assign not_nop = (|inst[`INST_W-1:`SH_LSB]) | (|func);

	always_comb begin
		inst_name = INST_INVALID;
		case (op)
			`OP_SPECIAL: begin
				case (func)
					`FN_ADD:     inst_name = INST_ADD;
					`FN_ADDU:    inst_name = INST_ADDU;
					`FN_SUB:     inst_name = INST_SUB;
					`FN_SUBU:    inst_name = INST_SUBU;
					`FN_SLT:     inst_name = INST_SLT;
					`FN_SLTU:    inst_name = INST_SLTU;
					`FN_AND:     inst_name = INST_AND;
					`FN_OR:      inst_name = INST_OR;
					`FN_XOR:     inst_name = INST_XOR;
					`FN_NOR:     inst_name = INST_NOR;
					`FN_SLL:     inst_name = INST_SLL;
					`FN_SLLV:    inst_name = INST_SLLV;
					`FN_SRA:     inst_name = INST_SRA;
					`FN_SRAV:    inst_name = INST_SRAV;
					`FN_SRL:     inst_name = INST_SRL;
					`FN_SRLV:    inst_name = INST_SRLV;
					`FN_MULT:    inst_name = INST_MULT;
					`FN_MULTU:   inst_name = INST_MULTU;
					`FN_DIV:     inst_name = INST_DIV;
					`FN_DIVU:    inst_name = INST_DIVU;
					`FN_JR:      inst_name = INST_JR;
					`FN_JALR:    inst_name = INST_JALR;
					`FN_MFHI:    inst_name = INST_MFHI;
					`FN_MFLO:    inst_name = INST_MFLO;
					`FN_MTHI:    inst_name = INST_MTHI;
					`FN_MTLO:    inst_name = INST_MTLO;
					`FN_BREAK:   inst_name = INST_BREAK;
					`FN_SYSCALL: inst_name = INST_SYSCALL;
					default:     inst_name = INST_INVALID;
				endcase
			end
			`OP_REGIMM: begin
				case (rt)
					`RT_BLTZ:   inst_name = INST_BLTZ;
					`RT_BGEZ:   inst_name = INST_BGEZ;
					`RT_BLTZAL: inst_name = INST_BLTZAL;
					`RT_BGEZAL: inst_name = INST_BGEZAL;
					default:    inst_name = INST_INVALID;
				endcase
			end
			`OP_COP0: begin
				if (rs[`REG_W-1]) begin	// co field set, only eret kept
					if (func == `FN_ERET)
						inst_name = INST_ERET;
				end else if (rs == `RS_MF) begin
					inst_name = INST_MFC0;
				end else if (rs == `RS_MT) begin
					inst_name = INST_MTC0;
				end
			end
			`OP_SPECIAL2: begin
				if (func == `FN_MUL)
					inst_name = INST_MUL;
			end
			`OP_ADDI:  inst_name = INST_ADDI;
			`OP_ADDIU: inst_name = INST_ADDIU;
			`OP_SLTI:  inst_name = INST_SLTI;
			`OP_SLTIU: inst_name = INST_SLTIU;
			`OP_ANDI:  inst_name = INST_ANDI;
			`OP_ORI:   inst_name = INST_ORI;
			`OP_XORI:  inst_name = INST_XORI;
			`OP_LUI:   inst_name = INST_LUI;
			`OP_BEQ:   inst_name = INST_BEQ;
			`OP_BEQL:  inst_name = INST_BEQL;
			`OP_BNE:   inst_name = INST_BNE;
			`OP_BGTZ:  inst_name = INST_BGTZ;
			`OP_BLEZ:  inst_name = INST_BLEZ;
			`OP_J:     inst_name = INST_J;
			`OP_JAL:   inst_name = INST_JAL;
			`OP_LB:    inst_name = INST_LB;
			`OP_LBU:   inst_name = INST_LBU;
			`OP_LH:    inst_name = INST_LH;
			`OP_LHU:   inst_name = INST_LHU;
			`OP_LW:    inst_name = INST_LW;
			`OP_SB:    inst_name = INST_SB;
			`OP_SH:    inst_name = INST_SH;
			`OP_SW:    inst_name = INST_SW;
			default:   inst_name = INST_INVALID;
		endcase
	end

endmodule

// File: inst_decode_top.f
+incdir+design
+incdir+verif
design/decode_pkg.sv
design/inst_identify.sv
design/datapath_ctrl_gen.sv
design/flow_ctrl_gen.sv
design/id_ctrl_reg.sv
design/inst_decode_top.sv
verif/tb_inst_decode.sv

// File: verif/decode_vectors.svh
// Decode test vectors
// Columns: instruction word, expected control bus, expected branch/jump
// vector, expected delay-slot flag.
// Bus fields, msb first: add_sub, ls_class, invalid/eret/break/syscall,
// hilo_mode, not_nop/load/r2_r/r1_r, alub_sel, alua_sel, ext_sel, cp0_we,
// din_sel, rw_sel, regs_we/r2_sel/r1_sel, alu_op

`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

	task automatic load_vectors();
		// register-register arithmetic and logic, rd=8 rs=9 rt=10
		add_row(32'h012a4020, 34'b01_000_0000_00_1011_00_00_00_0_110_10_110_0101, 11'h000, 1'b0);
		add_row(32'h012a4021, 34'b00_000_0000_00_1011_00_00_00_0_110_10_110_0101, 11'h000, 1'b0);
		add_row(32'h012a4022, 34'b10_000_0000_00_1011_00_00_00_0_110_10_110_0110, 11'h000, 1'b0);
		add_row(32'h012a4023, 34'b00_000_0000_00_1011_00_00_00_0_110_10_110_0110, 11'h000, 1'b0);
		add_row(32'h012a402a, 34'b00_000_0000_00_1011_00_00_00_0_110_10_110_1011, 11'h000, 1'b0);
		add_row(32'h012a402b, 34'b00_000_0000_00_1011_00_00_00_0_110_10_110_1101, 11'h000, 1'b0);
		add_row(32'h012a4024, 34'b00_000_0000_00_1011_00_00_00_0_110_10_110_0111, 11'h000, 1'b0);
		add_row(32'h012a4025, 34'b00_000_0000_00_1011_00_00_00_0_110_10_110_1000, 11'h000, 1'b0);
		add_row(32'h012a4026, 34'b00_000_0000_00_1011_00_00_00_0_110_10_110_1001, 11'h000, 1'b0);
		add_row(32'h012a4027, 34'b00_000_0000_00_1011_00_00_00_0_110_10_110_1010, 11'h000, 1'b0);
		// sllv srav srlv
		add_row(32'h012a4004, 34'b00_000_0000_00_1011_00_00_00_0_110_10_101_0000, 11'h000, 1'b0);
		add_row(32'h012a4007, 34'b00_000_0000_00_1011_00_00_00_0_110_10_101_0001, 11'h000, 1'b0);
		add_row(32'h012a4006, 34'b00_000_0000_00_1011_00_00_00_0_110_10_101_0010, 11'h000, 1'b0);
		// sll sra srl by 3
		add_row(32'h000a40c0, 34'b00_000_0000_00_1010_01_01_10_0_110_10_110_0000, 11'h000, 1'b0);
		add_row(32'h000a40c3, 34'b00_000_0000_00_1010_01_01_10_0_110_10_110_0001, 11'h000, 1'b0);
		add_row(32'h000a40c2, 34'b00_000_0000_00_1010_01_01_10_0_110_10_110_0010, 11'h000, 1'b0);
		// addi addiu slti sltiu andi ori xori lui
		add_row(32'h212a0010, 34'b01_000_0000_00_1001_01_00_00_0_110_01_100_0101, 11'h000, 1'b0);
		add_row(32'h252a0010, 34'b00_000_0000_00_1001_01_00_00_0_110_01_100_0101, 11'h000, 1'b0);
		add_row(32'h292a0010, 34'b00_000_0000_00_1001_01_00_00_0_110_01_100_1011, 11'h000, 1'b0);
		add_row(32'h2d2a0010, 34'b00_000_0000_00_1001_01_00_00_0_110_01_100_1101, 11'h000, 1'b0);
		add_row(32'h312a00ff, 34'b00_000_0000_00_1001_01_00_01_0_110_01_100_0111, 11'h000, 1'b0);
		add_row(32'h352a00ff, 34'b00_000_0000_00_1001_01_00_01_0_110_01_100_1000, 11'h000, 1'b0);
		add_row(32'h392a00ff, 34'b00_000_0000_00_1001_01_00_01_0_110_01_100_1001, 11'h000, 1'b0);
		add_row(32'h3c0a1234, 34'b00_000_0000_00_1000_11_10_01_0_110_01_100_0000, 11'h000, 1'b0);
		// mult multu div divu mul
		add_row(32'h012a0018, 34'b00_000_0000_11_1011_00_00_00_0_000_00_010_1101, 11'h000, 1'b0);
		add_row(32'h012a0019, 34'b00_000_0000_11_1011_00_00_00_0_000_00_010_0011, 11'h000, 1'b0);
		add_row(32'h012a001a, 34'b00_000_0000_11_1011_00_00_00_0_000_00_010_1110, 11'h000, 1'b0);
		add_row(32'h012a001b, 34'b00_000_0000_11_1011_00_00_00_0_000_00_010_0100, 11'h000, 1'b0);
		add_row(32'h712a4002, 34'b00_000_0000_00_1000_00_00_00_0_110_10_110_1101, 11'h000, 1'b0);
		// beq bne blez bgtz beql
		add_row(32'h112a0004, 34'b00_000_0000_00_1011_00_00_00_0_000_00_010_0000, 11'h001, 1'b1);
		add_row(32'h152a0004, 34'b00_000_0000_00_1011_00_00_00_0_000_00_010_0000, 11'h002, 1'b1);
		add_row(32'h19200004, 34'b00_000_0000_00_1011_00_00_00_0_000_00_010_0000, 11'h010, 1'b1);
		add_row(32'h1d200004, 34'b00_000_0000_00_1011_00_00_00_0_000_00_010_0000, 11'h008, 1'b1);
		add_row(32'h512a0004, 34'b00_000_0000_00_1011_00_00_00_0_000_00_010_0000, 11'h401, 1'b1);
		// bltz bgez bltzal bgezal
		add_row(32'h05200004, 34'b00_000_0000_00_1001_10_00_00_0_000_00_000_0000, 11'h020, 1'b1);
		add_row(32'h05210004, 34'b00_000_0000_00_1001_10_00_00_0_000_00_000_0000, 11'h004, 1'b1);
		add_row(32'h05300004, 34'b00_000_0000_00_1001_10_00_00_0_001_00_100_0000, 11'h040, 1'b1);
		add_row(32'h05310004, 34'b00_000_0000_00_1001_10_00_00_0_001_00_100_0000, 11'h080, 1'b1);
		// j jal jr jalr
		add_row(32'h08000010, 34'b00_000_0000_00_1000_00_00_00_0_000_00_000_0000, 11'h100, 1'b1);
		add_row(32'h0c000010, 34'b00_000_0000_00_1000_00_00_00_0_001_00_100_0000, 11'h100, 1'b1);
		add_row(32'h03e00008, 34'b00_000_0000_00_1001_00_00_00_0_000_00_000_0000, 11'h200, 1'b1);
		add_row(32'h0120f809, 34'b00_000_0000_00_1001_00_00_00_0_001_10_100_0000, 11'h200, 1'b1);
		// mfhi mflo mthi mtlo
		add_row(32'h00004010, 34'b00_000_0000_00_1000_00_00_00_0_100_10_100_0000, 11'h000, 1'b0);
		add_row(32'h00004012, 34'b00_000_0000_00_1000_00_00_00_0_101_10_100_0000, 11'h000, 1'b0);
		add_row(32'h01200011, 34'b00_000_0000_10_1001_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'h01200013, 34'b00_000_0000_01_1001_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		// break syscall eret mfc0 mtc0
		add_row(32'h0000000d, 34'b00_000_0010_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'h0000000c, 34'b00_000_0001_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'h42000018, 34'b00_000_0100_00_1010_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'h400a6000, 34'b00_000_0000_00_1000_00_00_00_0_011_01_100_0000, 11'h000, 1'b0);
		add_row(32'h408a6000, 34'b00_000_0000_00_1010_00_00_00_1_000_00_010_0000, 11'h000, 1'b0);
		// lb lbu lh lhu lw sb sh sw
		add_row(32'h812a0004, 34'b00_000_0000_00_1101_01_00_00_0_010_01_100_0101, 11'h000, 1'b0);
		add_row(32'h912a0004, 34'b00_001_0000_00_1101_01_00_00_0_010_01_100_0101, 11'h000, 1'b0);
		add_row(32'h852a0004, 34'b00_010_0000_00_1101_01_00_00_0_010_01_100_0101, 11'h000, 1'b0);
		add_row(32'h952a0004, 34'b00_011_0000_00_1101_01_00_00_0_010_01_100_0101, 11'h000, 1'b0);
		add_row(32'h8d2a0004, 34'b00_100_0000_00_1101_01_00_00_0_010_01_100_0101, 11'h000, 1'b0);
		add_row(32'ha12a0004, 34'b00_101_0000_00_1011_01_00_00_0_000_00_010_0101, 11'h000, 1'b0);
		add_row(32'ha52a0004, 34'b00_110_0000_00_1011_01_00_00_0_000_00_010_0101, 11'h000, 1'b0);
		add_row(32'had2a0004, 34'b00_111_0000_00_1011_01_00_00_0_000_00_010_0101, 11'h000, 1'b0);
		// dropped encodings: movn ll teq lwl tlbwi cache clz
		add_row(32'h012a400b, 34'b00_000_1000_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'hc12a0004, 34'b00_000_1000_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'h012a0034, 34'b00_000_1000_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'h892a0004, 34'b00_000_1000_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'h42000002, 34'b00_000_1000_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'hbd2a0000, 34'b00_000_1000_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		add_row(32'h712a4020, 34'b00_000_1000_00_1000_00_00_00_0_000_00_000_0000, 11'h000, 1'b0);
		// all-zero word is sll with not_nop clear
		add_row(32'h00000000, 34'b00_000_0000_00_0010_01_01_10_0_110_10_110_0000, 11'h000, 1'b0);
	endtask

`endif

// File: verif/tb_inst_decode.sv
// Testbench for the instruction decode stage
// Checks reset, every table row with an idle cycle after it, and a run
// of randomly picked rows strobed on consecutive cycles.

`timescale 1ns/1ps
`include "decode_consts.svh"

module tb_inst_decode;

	import decode_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int RAND_COUNT   = 200;

	logic                   clk;
	logic                   rst;
	logic                   inst_valid;
	logic [`INST_W-1:0]     inst;
	logic [`CTRL_BUS_W-1:0] control_bus;
	logic [`BRANCH_W-1:0]   branch_jump;
	logic                   in_delayslot;
	logic                   ctrl_valid;

	logic [`INST_W-1:0]     vec_inst[$];
	logic [`CTRL_BUS_W-1:0] vec_bus[$];
	logic [`BRANCH_W-1:0]   vec_bj[$];
	logic                   vec_ds[$];

	logic rows_loaded;
	int   pass_count;
	int   fail_count;
	int   test_errors;

	inst_decode_top uut (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.control_bus  (control_bus),
		.branch_jump  (branch_jump),
		.in_delayslot (in_delayslot),
		.ctrl_valid   (ctrl_valid)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;	// 100 ns period

	task automatic add_row(input logic [`INST_W-1:0] word, input logic [`CTRL_BUS_W-1:0] bus,
			input logic [`BRANCH_W-1:0] bj, input logic ds);
		vec_inst.push_back(word);
		vec_bus.push_back(bus);
		vec_bj.push_back(bj);
		vec_ds.push_back(ds);
	endtask

	`include "decode_vectors.svh"

	function automatic logic [31:0] xorshift_next(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic compare_outputs(input logic exp_valid, input logic [`CTRL_BUS_W-1:0] exp_bus,
			input logic [`BRANCH_W-1:0] exp_bj, input logic exp_ds, input string what);
		if (ctrl_valid !== exp_valid) begin
			$display("ERR %0t: %s ctrl_valid %b, expected %b", $time, what, ctrl_valid, exp_valid);
			test_errors++;
		end
		if (control_bus !== exp_bus) begin
			$display("ERR %0t: %s control_bus %b, expected %b", $time, what, control_bus, exp_bus);
			test_errors++;
		end
		if (branch_jump !== exp_bj) begin
			$display("ERR %0t: %s branch_jump %h, expected %h", $time, what, branch_jump, exp_bj);
			test_errors++;
		end
		if (in_delayslot !== exp_ds) begin
			$display("ERR %0t: %s in_delayslot %b, expected %b", $time, what, in_delayslot, exp_ds);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// limit grows with the table and the random run
	initial begin
		int limit;
		wait (rows_loaded === 1'b1);
		limit = RESET_CYCLES + vec_inst.size() * 3 + RAND_COUNT * 2 + 20;
		repeat (limit) @(posedge clk);
		$display("watchdog: run timed out after %0d clock cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] rng;
		int          pick;
		int          n_rows;
		rst         = 1'b1;
		inst_valid  = 1'b0;
		inst        = '0;
		rows_loaded = 1'b0;
		pass_count  = 0;
		fail_count  = 0;
		test_errors = 0;
		rng         = 32'hfe6c_affc;
		load_vectors();
		n_rows      = vec_inst.size();
		rows_loaded = 1'b1;

		// strobe a jal during reset, reset must win
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			compare_outputs(1'b0, '0, '0, 1'b0, "reset");
			inst_valid = 1'b1;
			inst       = 32'h0c000010;
		end
		rst        = 1'b0;
		inst_valid = 1'b0;
		@(negedge clk);
		compare_outputs(1'b0, '0, '0, 1'b0, "after reset");
		finish_test("reset");

		for (int i = 0; i < n_rows; i++) begin
			inst_valid = 1'b1;
			inst       = vec_inst[i];
			@(negedge clk);
			rng        = xorshift_next(rng);
			inst_valid = 1'b0;
			inst       = rng;	// junk while idle
			compare_outputs(1'b1, vec_bus[i], vec_bj[i], vec_ds[i],
				$sformatf("row %0d strobe", i));
			@(negedge clk);
			compare_outputs(1'b0, vec_bus[i], vec_bj[i], vec_ds[i],
				$sformatf("row %0d hold", i));
			finish_test($sformatf("row %0d inst %h", i, vec_inst[i]));
		end

		for (int n = 0; n < RAND_COUNT; n++) begin
			rng        = xorshift_next(rng);
			pick       = rng % n_rows;
			inst_valid = 1'b1;
			inst       = vec_inst[pick];
			@(negedge clk);
			compare_outputs(1'b1, vec_bus[pick], vec_bj[pick], vec_ds[pick],
				$sformatf("back-to-back %0d row %0d", n, pick));
		end
		inst_valid = 1'b0;
		@(negedge clk);
		if (ctrl_valid !== 1'b0) begin
			$display("ERR %0t: ctrl_valid still high after the last strobe", $time);
			test_errors++;
		end
		finish_test("back-to-back");

		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
